// File: hdl/snes_rom_arb_params.svh
`ifndef SNES_ROM_ARB_PARAMS_SVH
`define SNES_ROM_ARB_PARAMS_SVH

// Bus widths
`define SNES_ADDR_W 24
`define ROM_ADDR_W 23

// Input filter depth
`define SYNC_TAPS 8
`define ADDR_TAPS 7

// ROM access length, addr state lasts this value plus one
`define ROM_CYCLE_LEN 7

// About 1 ms of clk2 without a CPU clock edge
`define DEAD_TIMEOUT 86400
`define DEAD_CNT_W 18

`endif

// File: hdl/snes_rom_arb_pkg.sv
`include "snes_rom_arb_params.svh"

package snes_rom_arb_pkg;

  typedef logic [`SNES_ADDR_W-1:0] snes_addr_t; // Console or byte address
  typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;   // 16-bit word address
  typedef logic [7:0] byte_t;
  typedef logic [15:0] rom_word_t;

  // One-hot arbiter states
  typedef enum logic [4:0] {
    idle    = 5'b00001,
    rd_addr = 5'b00010,
    rd_end  = 5'b00100,
    wr_addr = 5'b01000,
    wr_end  = 5'b10000
  } arb_state_e;

  // Filtered console bus
  typedef struct packed {
    snes_addr_t addr;
    logic       read_n;
    logic       write_n;
    logic       romsel_n;
    logic       cpu_clk;
  } snes_bus_t;

  typedef struct packed {
    logic cycle_start;
    logic cycle_end;
  } snes_evt_t;

  typedef struct packed {
    logic       rrq;
    logic       wrq;
    snes_addr_t addr;
    byte_t      wdata;
  } mcu_req_t;

  typedef struct packed {
    logic       mcu_hit;    // MCU owns the ROM bus
    logic       mcu_wr_hit;
    snes_addr_t addr;       // Latched MCU byte address
  } rom_grant_t;

endpackage

// File: hdl/snes_bus_sync.sv
`timescale 1ns/100ps
`include "snes_rom_arb_params.svh"

module snes_bus_sync (
  input  logic                         clk2,
  input  logic                         rst_n,
  input  snes_rom_arb_pkg::snes_addr_t snes_addr_in,
  input  logic                         snes_read_n_in,
  input  logic                         snes_write_n_in,
  input  logic                         snes_romsel_n_in,
  input  logic                         snes_cpu_clk_in,
  output snes_rom_arb_pkg::snes_bus_t  bus,
  output snes_rom_arb_pkg::snes_evt_t  evt
);
  import snes_rom_arb_pkg::*;

  localparam int PAT_W = `SYNC_TAPS - 2;

  logic [`SYNC_TAPS-1:0] read_sr;
  logic [`SYNC_TAPS-1:0] write_sr;
  logic [`SYNC_TAPS-1:0] romsel_sr;
  logic [`SYNC_TAPS-1:0] clk_sr;
  snes_addr_t            addr_dly [`ADDR_TAPS];
  logic [PAT_W-1:0]      clk_and;   // Adjacent tap pairs, both high
  logic [PAT_W-1:0]      clk_or;    // Adjacent tap pairs, either high

  ////////////////////////////////////////////////////////////////////////////
  // Oversampling shift registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      read_sr   <= '1;  // Strobes idle high
      write_sr  <= '1;
      romsel_sr <= '1;
      clk_sr    <= '0;
    end else begin
      read_sr   <= {read_sr[`SYNC_TAPS-2:0], snes_read_n_in};
      write_sr  <= {write_sr[`SYNC_TAPS-2:0], snes_write_n_in};
      romsel_sr <= {romsel_sr[`SYNC_TAPS-2:0], snes_romsel_n_in};
      clk_sr    <= {clk_sr[`SYNC_TAPS-2:0], snes_cpu_clk_in};
    end
  end

  // Address settles later than the strobes
  always_ff @(posedge clk2) begin
    addr_dly[0] <= snes_addr_in;
    for (int i = 1; i < `ADDR_TAPS; i++) begin
      addr_dly[i] <= addr_dly[i-1];
    end
  end

  // Glitch filtered levels
  assign bus.addr     = addr_dly[`ADDR_TAPS-1] & addr_dly[`ADDR_TAPS-2];
  assign bus.read_n   = read_sr[1] & read_sr[2];
  assign bus.write_n  = write_sr[1] & write_sr[2];
  assign bus.romsel_n = romsel_sr[1] & romsel_sr[2];
  assign bus.cpu_clk  = clk_sr[1] & clk_sr[2];

  ////////////////////////////////////////////////////////////////////////////
  // CPU clock edge patterns
  ////////////////////////////////////////////////////////////////////////////
  assign clk_and = clk_sr[`SYNC_TAPS-1:2] & clk_sr[`SYNC_TAPS-2:1];
  assign clk_or  = clk_sr[`SYNC_TAPS-1:2] | clk_sr[`SYNC_TAPS-2:1];

  assign evt.cycle_start = (clk_and == PAT_W'(2'b11));                  // Lows, then rise
  assign evt.cycle_end   = (clk_or == {3'b111, {(PAT_W-3){1'b0}}});    // Highs, then fall

  a_evt_exclusive: assert property (
    @(posedge clk2) disable iff (!rst_n) !(evt.cycle_start && evt.cycle_end)
  );

endmodule

// File: hdl/snes_liveness.sv
`timescale 1ns/100ps
`include "snes_rom_arb_params.svh"

module snes_liveness (
  input  logic clk2,
  input  logic rst_n,
  input  logic cpu_clk,
  output logic dead,
  output logic alive_edge
);

  logic [`DEAD_CNT_W-1:0] idle_cnt;

  // Watchdog, counts clk2 cycles with the CPU clock low
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      idle_cnt <= '0;
    end else if (cpu_clk) begin
      idle_cnt <= '0;
    end else if (!(&idle_cnt)) begin
      idle_cnt <= idle_cnt + 1'b1;  // Saturates
    end
  end

  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      dead       <= 1'b1;  // No console until its clock shows up
      alive_edge <= 1'b0;
    end else begin
      alive_edge <= dead & cpu_clk;
      if (cpu_clk) begin
        dead <= 1'b0;
      end else if (idle_cnt > `DEAD_CNT_W'(`DEAD_TIMEOUT)) begin
        dead <= 1'b1;
      end
    end
  end

  // Return of the clock only counts after a dead period
  a_alive_after_dead: assert property (
    @(posedge clk2) disable iff (!rst_n) alive_edge |-> $past(dead)
  );

endmodule

// File: hdl/mcu_rom_arbiter.sv
`timescale 1ns/100ps
`include "snes_rom_arb_params.svh"

module mcu_rom_arbiter (
  input  logic                         clk2,
  input  logic                         rst_n,
  input  snes_rom_arb_pkg::mcu_req_t   req,
  input  snes_rom_arb_pkg::snes_evt_t  evt,
  input  logic                         romsel_n,
  input  logic                         dead,
  input  logic                         alive_edge,
  input  snes_rom_arb_pkg::byte_t      rom_rdata,
  output snes_rom_arb_pkg::rom_grant_t grant,
  output logic                         mcu_rdy,
  output snes_rom_arb_pkg::byte_t      mcu_rdata
);
  import snes_rom_arb_pkg::*;

  arb_state_e state;
  logic [3:0] delay_cnt;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;
  logic       rd_hit;
  logic       wr_hit;
  snes_addr_t req_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (req.rrq) begin  // Read wins over write
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == rd_end || state == wr_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (req.rrq || req.wrq) begin
      req_addr <= req.addr;
    end
  end

  // Cycle that started without a ROM select leaves the bus free
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= evt.cycle_start & romsel_n;
    end
  end

  assign free_slot = evt.cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // ROM access FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk2) begin
    if (!rst_n) begin
      state     <= idle;
      delay_cnt <= '0;
    end else if (alive_edge) begin
      state <= idle;  // Console woke up mid access, pending request retries
    end else begin
      case (state)
        idle: begin
          if (free_slot || dead) begin
            if (rd_pend) begin
              state     <= rd_addr;
              delay_cnt <= 4'(`ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state     <= wr_addr;
              delay_cnt <= 4'(`ROM_CYCLE_LEN);
            end
          end
        end
        rd_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= rd_end;
        end
        wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= wr_end;
        end
        default: state <= idle;  // Both end states
      endcase
    end
  end

  // ROM data has settled by the last addr cycle
  always_ff @(posedge clk2) begin
    if (state == rd_addr && delay_cnt == '0) begin
      mcu_rdata <= rom_rdata;
    end
  end

  assign rd_hit = |(state & rd_addr);
  assign wr_hit = |(state & wr_addr);

  assign grant.mcu_hit    = rd_hit | wr_hit;
  assign grant.mcu_wr_hit = wr_hit;
  assign grant.addr       = req_addr;

  a_req_when_rdy: assert property (
    @(posedge clk2) disable iff (!rst_n) (req.rrq || req.wrq) |-> mcu_rdy
  );

  a_no_rd_wr_overlap: assert property (
    @(posedge clk2) disable iff (!rst_n) !(rd_hit && wr_hit)
  );

endmodule

// File: hdl/rom_port_mux.sv
`timescale 1ns/100ps
`include "snes_rom_arb_params.svh"

module rom_port_mux (
  input  snes_rom_arb_pkg::snes_bus_t  bus,
  input  snes_rom_arb_pkg::rom_grant_t grant,
  input  snes_rom_arb_pkg::byte_t      mcu_wdata,
  input  snes_rom_arb_pkg::snes_addr_t rom_mask,
  input  snes_rom_arb_pkg::rom_word_t  rom_dq_in,
  output snes_rom_arb_pkg::rom_addr_t  rom_addr,
  output logic                         rom_bhe_n,
  output logic                         rom_ble_n,
  output logic                         rom_we_n,
  output snes_rom_arb_pkg::rom_word_t  rom_dq_out,
  output logic                         rom_dq_oe,
  output snes_rom_arb_pkg::byte_t      rom_rdata,
  output snes_rom_arb_pkg::byte_t      snes_data_out,
  output logic                         snes_data_oe
);
  import snes_rom_arb_pkg::*;

  snes_addr_t sel_addr;
  logic       addr0;
  logic       rom_hit;
  byte_t      lane_data;

  ////////////////////////////////////////////////////////////////////////////
  // Address and byte lanes
  ////////////////////////////////////////////////////////////////////////////
  assign sel_addr = grant.mcu_hit ? grant.addr : (bus.addr & rom_mask);
  assign addr0    = sel_addr[0];
  assign rom_addr = sel_addr[`SNES_ADDR_W-1:1];

  // Odd byte sits in the low lane
  assign rom_bhe_n = addr0;
  assign rom_ble_n = ~addr0;

  assign rom_hit = ~bus.romsel_n;

  always_comb begin
    if (rom_hit && bus.cpu_clk) begin
      rom_we_n = bus.write_n;  // Console write strobe follows the bus
    end else if (grant.mcu_wr_hit) begin
      rom_we_n = 1'b0;
    end else begin
      rom_we_n = 1'b1;
    end
  end

  // Same byte on both lanes so BHE/BLE pick the one written
  assign rom_dq_out = {mcu_wdata, mcu_wdata};
  assign rom_dq_oe  = grant.mcu_wr_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////
  assign lane_data = addr0 ? rom_dq_in[7:0] : rom_dq_in[15:8];

  assign rom_rdata     = lane_data;
  assign snes_data_out = lane_data;
  assign snes_data_oe  = rom_hit & ~bus.read_n & ~grant.mcu_hit;  // Console read while bus not lent

endmodule

// File: hdl/snes_rom_arb_top.sv
`timescale 1ns/100ps

module snes_rom_arb_top (
  input  logic                         clk2,
  input  logic                         rst_n,
  input  snes_rom_arb_pkg::snes_addr_t snes_addr_in,
  input  logic                         snes_read_n_in,
  input  logic                         snes_write_n_in,
  input  logic                         snes_romsel_n_in,
  input  logic                         snes_cpu_clk_in,
  input  logic                         mcu_rrq,
  input  logic                         mcu_wrq,
  input  snes_rom_arb_pkg::snes_addr_t mcu_addr,
  input  snes_rom_arb_pkg::byte_t      mcu_wdata,
  input  snes_rom_arb_pkg::snes_addr_t rom_mask,
  input  snes_rom_arb_pkg::rom_word_t  rom_dq_in,
  output logic                         mcu_rdy,
  output snes_rom_arb_pkg::byte_t      mcu_rdata,
  output snes_rom_arb_pkg::rom_addr_t  rom_addr,
  output logic                         rom_bhe_n,
  output logic                         rom_ble_n,
  output logic                         rom_we_n,
  output snes_rom_arb_pkg::rom_word_t  rom_dq_out,
  output logic                         rom_dq_oe,
  output snes_rom_arb_pkg::byte_t      snes_data_out,
  output logic                         snes_data_oe
);
  import snes_rom_arb_pkg::*;

  snes_bus_t  bus;
  snes_evt_t  evt;
  mcu_req_t   req;
  rom_grant_t grant;
  byte_t      rom_rdata;
  logic       dead;
  logic       alive_edge;

  assign req = '{rrq: mcu_rrq, wrq: mcu_wrq, addr: mcu_addr, wdata: mcu_wdata};

  snes_bus_sync u_sync (
    .clk2(clk2), .rst_n(rst_n),
    .snes_addr_in(snes_addr_in), .snes_read_n_in(snes_read_n_in),
    .snes_write_n_in(snes_write_n_in), .snes_romsel_n_in(snes_romsel_n_in),
    .snes_cpu_clk_in(snes_cpu_clk_in), .bus(bus), .evt(evt)
  );

  snes_liveness u_live (
    .clk2(clk2), .rst_n(rst_n), .cpu_clk(bus.cpu_clk),
    .dead(dead), .alive_edge(alive_edge)
  );

  mcu_rom_arbiter u_arb (
    .clk2(clk2), .rst_n(rst_n), .req(req), .evt(evt), .romsel_n(bus.romsel_n),
    .dead(dead), .alive_edge(alive_edge), .rom_rdata(rom_rdata),
    .grant(grant), .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata)
  );

  rom_port_mux u_mux (
    .bus(bus), .grant(grant), .mcu_wdata(req.wdata), .rom_mask(rom_mask),
    .rom_dq_in(rom_dq_in), .rom_addr(rom_addr), .rom_bhe_n(rom_bhe_n),
    .rom_ble_n(rom_ble_n), .rom_we_n(rom_we_n), .rom_dq_out(rom_dq_out),
    .rom_dq_oe(rom_dq_oe), .rom_rdata(rom_rdata),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe)
  );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk2,
  output logic rst_n
);

  initial begin
    clk2 = 1'b0;
    forever #(PERIOD / 2) clk2 = ~clk2;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk2);
    #(PERIOD / 10) rst_n = 1'b1;
  end

endmodule

// File: bench/tb_snes_rom_arb.sv
`timescale 1ns/100ps
`include "snes_rom_arb_params.svh"

module tb_snes_rom_arb;
  import snes_rom_arb_pkg::*;

  localparam int DRIVE_DLY = 10;
  localparam int RDY_LIMIT = 400;   // Cycles allowed per wait
  localparam int N_OPS     = 20;
  localparam snes_addr_t SPAN_MASK = 24'h01_ffff;  // Byte range of the 64K-word model

  logic clk2, rst_n;
  snes_addr_t snes_addr_in, mcu_addr, rom_mask;
  logic snes_read_n_in, snes_write_n_in, snes_romsel_n_in, snes_cpu_clk_in;
  logic mcu_rrq, mcu_wrq, mcu_rdy;
  byte_t mcu_wdata, mcu_rdata, snes_data_out;
  rom_word_t rom_dq_in, rom_dq_out;
  rom_addr_t rom_addr;
  logic rom_bhe_n, rom_ble_n, rom_we_n, rom_dq_oe, snes_data_oe;

  rom_word_t rom_mem [65536];
  rom_word_t ref_mem [65536];
  logic [15:0] wr_word_q;
  logic wr_bhe_q, wr_ble_q;
  rom_word_t wr_data_q;
  int mism_cnt, fail_cnt, rst_cnt;
  logic console_run;
  snes_addr_t addr_list [N_OPS];
  snes_addr_t a;

  clk_gen u_clk (.clk2(clk2), .rst_n(rst_n));

  snes_rom_arb_top uut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // ROM / PSRAM model
  ////////////////////////////////////////////////////////////////////////////
  function automatic rom_word_t fill_word(input logic [15:0] idx);
    return (idx * 16'h9e37) ^ {idx[7:0], idx[15:8]};
  endfunction

  initial begin
    for (int i = 0; i < 65536; i++) begin
      rom_mem[i] = fill_word(16'(i));
      ref_mem[i] = fill_word(16'(i));
    end
  end

  assign rom_dq_in = rom_mem[rom_addr[15:0]];

  // Address and lanes captured mid cycle and committed on the strobe's rise
  always @(negedge clk2) begin
    if (rom_we_n === 1'b0) begin
      wr_word_q <= rom_addr[15:0];
      wr_bhe_q  <= rom_bhe_n;
      wr_ble_q  <= rom_ble_n;
      wr_data_q <= (rom_dq_oe === 1'b1) ? rom_dq_out : 'x;  // Data bus floats when not driven
    end
  end

  always @(posedge rom_we_n) begin
    if (rst_n === 1'b1) begin
      if (!wr_ble_q) rom_mem[wr_word_q][7:0] = wr_data_q[7:0];
      if (!wr_bhe_q) rom_mem[wr_word_q][15:8] = wr_data_q[15:8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic byte_t expected_byte(input snes_addr_t addr);
    rom_word_t w;
    w = ref_mem[addr[16:1]];
    return addr[0] ? w[7:0] : w[15:8];  // Odd byte in the low lane
  endfunction

  task automatic step_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk2);
      #DRIVE_DLY;
    end
  endtask

  task automatic wait_ready(input string name, output bit ok);
    int cnt;
    cnt = 0;
    while (mcu_rdy !== 1'b1 && cnt < RDY_LIMIT) begin
      step_cycles(1);
      cnt++;
    end
    ok = (mcu_rdy === 1'b1);
    if (!ok) begin
      fail_cnt++;
      $display("%s: mcu_rdy stayed low, request not issued", name);
    end
  endtask

  task automatic wait_done(input string name, input bit watch_we, output bit ok);
    int cnt;
    cnt = 0;
    ok  = 1'b0;
    while (!ok && cnt < RDY_LIMIT) begin
      if (watch_we && rom_we_n !== 1'b1) begin
        fail_cnt++;
        $display("%s: rom_we_n went low during an MCU read", name);
      end
      step_cycles(1);
      cnt++;
      ok = (mcu_rdy === 1'b1);
    end
    if (!ok) begin
      fail_cnt++;
      $display("%s: access did not complete within %0d cycles", name, RDY_LIMIT);
    end
  endtask

  task automatic mcu_read(input snes_addr_t addr, input string name, input bit watch_we);
    bit ok;
    byte_t exp;
    wait_ready(name, ok);
    if (ok) begin
      mcu_addr = addr;
      mcu_rrq  = 1'b1;
      step_cycles(1);
      mcu_rrq  = 1'b0;
      wait_done(name, watch_we, ok);
      exp = expected_byte(addr);
      if (ok && mcu_rdata !== exp) begin
        mism_cnt++;
        $display("mismatch %s addr %h expected %h actual %h", name, addr, exp, mcu_rdata);
      end
    end
  endtask

  task automatic mcu_write(input snes_addr_t addr, input byte_t data, input string name);
    bit ok;
    wait_ready(name, ok);
    if (ok) begin
      mcu_addr  = addr;
      mcu_wdata = data;  // Held until done since the mux reads it unlatched
      mcu_wrq   = 1'b1;
      step_cycles(1);
      mcu_wrq   = 1'b0;
      wait_done(name, 1'b0, ok);
      if (ok && addr[0]) ref_mem[addr[16:1]][7:0] = data;
      if (ok && !addr[0]) ref_mem[addr[16:1]][15:8] = data;
    end
  endtask

  task automatic console_read(input snes_addr_t addr, input snes_addr_t mask);
    int cnt;
    byte_t exp;
    snes_addr_in     = addr;
    rom_mask         = mask;
    snes_romsel_n_in = 1'b0;
    snes_read_n_in   = 1'b0;
    step_cycles(`ADDR_TAPS + 2);  // Address delay line settles
    cnt = 0;
    while (snes_data_oe !== 1'b1 && cnt < RDY_LIMIT) begin
      step_cycles(1);
      cnt++;
    end
    exp = expected_byte(addr & mask);
    if (snes_data_oe !== 1'b1) begin
      fail_cnt++;
      $display("console_read: snes_data_oe never went high");
    end else if (snes_data_out !== exp) begin
      mism_cnt++;
      $display("mismatch console_read addr %h expected %h actual %h",
               addr & mask, exp, snes_data_out);
    end
    snes_romsel_n_in = 1'b1;
    snes_read_n_in   = 1'b1;
    step_cycles(4);
  endtask

  // Catches stray writes and wrong lanes anywhere in the array
  task automatic check_rom_image();
    for (int i = 0; i < 65536; i++) begin
      if (rom_mem[i] !== ref_mem[i]) begin
        mism_cnt++;
        $display("mismatch rom_image word %h expected %h actual %h", i, ref_mem[i], rom_mem[i]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'hbfa9_3959));
    mism_cnt = 0;
    fail_cnt = 0;
    console_run = 1'b0;
    snes_addr_in = '0;
    snes_read_n_in = 1'b1;
    snes_write_n_in = 1'b1;
    snes_romsel_n_in = 1'b1;
    snes_cpu_clk_in = 1'b0;  // Console stays dead until the live test
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    rom_mask = SPAN_MASK;

    rst_cnt = 0;
    while (rst_n !== 1'b1 && rst_cnt < 20) begin
      @(posedge clk2);
      #DRIVE_DLY;
      rst_cnt++;
    end
    if (rst_n !== 1'b1) begin
      fail_cnt++;
      $display("reset was never released");
    end
    step_cycles(1);

    // Reset state
    if (mcu_rdy !== 1'b1) begin
      mism_cnt++;
      $display("mismatch reset_rdy expected 1 actual %b", mcu_rdy);
    end
    if (rom_we_n !== 1'b1) begin
      mism_cnt++;
      $display("mismatch reset_we_n expected 1 actual %b", rom_we_n);
    end
    if (rom_dq_oe !== 1'b0 || snes_data_oe !== 1'b0) begin
      mism_cnt++;
      $display("mismatch reset_oe expected 00 actual %b%b", rom_dq_oe, snes_data_oe);
    end

    for (int i = 0; i < N_OPS; i++) begin
      a = 24'($urandom()) & SPAN_MASK;
      mcu_read(a, "dead_read", 1'b0);
    end

    for (int i = 0; i < N_OPS; i++) begin
      addr_list[i] = 24'($urandom()) & SPAN_MASK;
      mcu_write(addr_list[i], 8'($urandom()), "dead_write");
    end
    for (int i = 0; i < N_OPS; i++) begin
      mcu_read(addr_list[i], "readback", 1'b0);
    end

    for (int i = 0; i < 6; i++) begin
      console_read(24'($urandom()), 24'($urandom()) & SPAN_MASK);
    end
    rom_mask = SPAN_MASK;

    // MCU reads squeeze into free slots of a live console
    console_run = 1'b1;
    fork
      begin : console_bus
        int hi_len;
        int lo_len;
        for (int k = 0; k < 2000 && console_run; k++) begin
          hi_len = $urandom_range(8, 4);
          lo_len = $urandom_range(8, 4);
          snes_romsel_n_in = 1'($urandom_range(1, 0));
          snes_read_n_in   = snes_romsel_n_in;
          snes_addr_in     = 24'($urandom());
          snes_cpu_clk_in  = 1'b1;
          step_cycles(hi_len);
          snes_cpu_clk_in  = 1'b0;
          step_cycles(lo_len);
        end
      end
      begin : mcu_side
        for (int i = 0; i < N_OPS; i++) begin
          mcu_read(addr_list[$urandom_range(N_OPS - 1, 0)], "live_read", 1'b1);
        end
        console_run = 1'b0;
      end
    join
    snes_romsel_n_in = 1'b1;
    snes_read_n_in   = 1'b1;

    check_rom_image();

    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: snes_rom_arb.f
+incdir+hdl
hdl/snes_rom_arb_pkg.sv
hdl/snes_bus_sync.sv
hdl/snes_liveness.sv
hdl/mcu_rom_arbiter.sv
hdl/rom_port_mux.sv
hdl/snes_rom_arb_top.sv
bench/clk_gen.sv
bench/tb_snes_rom_arb.sv

// File: Bender.yml
package:
  name: snes_rom_arb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/snes_rom_arb_pkg.sv
      - hdl/snes_bus_sync.sv
      - hdl/snes_liveness.sv
      - hdl/mcu_rom_arbiter.sv
      - hdl/rom_port_mux.sv
      - hdl/snes_rom_arb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/clk_gen.sv
      - bench/tb_snes_rom_arb.sv
